// File: compile.f
+incdir+.
ifetch_pkg.sv
icache_arrays.sv
core_ifetch.sv
ifetch_csr.sv
ifetch_top.sv
tb_ifetch_mem.sv
tb_ifetch.sv

// File: run_sim.sh
#!/bin/sh
# Build the fetch stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_ifetch \
  && ./obj_dir/Vtb_ifetch > sim.log 2>&1 \
  || { echo "Build or simulation run failed, see sim.log"; exit 1; }

grep -q "ALL CHECKS PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// File: tb_ifetch.sv
`timescale 1ns/100ps
`include "ifetch_params.svh"

module tb_ifetch;
  import ifetch_pkg::*;

  // About 900 cycles of tests including the 256-cycle invalidate sweep
  localparam int TIMEOUT_CYCLES = 2000;

  logic                    clk, rst_n;
  apb_req_t                apb_req;
  apb_resp_t               apb_resp;
  fetch_req_t              fetch_req;
  logic                    fetch_ready, out_ready, clr;
  logic [31:0]             ppc;
  logic                    paddr_valid, uncached;
  logic [31:0]             out_vpc;
  logic [1:0]              out_valid;
  logic [1:0][31:0]        out_inst;
  logic [`IF_ATTACH_W-1:0] out_attached;
  cache_bus_req_t          bus_req;
  cache_bus_resp_t         bus_resp;
  logic [1:0]              mem_rnd;
  logic [31:0]             mem_lfsr, lfsr_q;
  int                      checks, errors;

  ifetch_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .apb_i         (apb_req),
    .apb_o         (apb_resp),
    .fetch_i       (fetch_req),
    .ready_o       (fetch_ready),
    .ppc_i         (ppc),
    .paddr_valid_i (paddr_valid),
    .uncached_i    (uncached),
    .vpc_o         (out_vpc),
    .valid_o       (out_valid),
    .inst_o        (out_inst),
    .attached_o    (out_attached),
    .ready_i       (out_ready),
    .clr_i         (clr),
    .bus_req_o     (bus_req),
    .bus_resp_i    (bus_resp)
  );

  tb_ifetch_mem u_mem (
    .clk    (clk),
    .rst_n  (rst_n),
    .rnd_i  (mem_rnd),
    .req_i  (bus_req),
    .resp_o (bus_resp)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[6:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // MMU stand-in gives ppc equal to vpc one cycle after acceptance
  always @(posedge clk) begin
    if (!rst_n) begin
      paddr_valid <= 1'b0;
    end else if (fetch_ready) begin
      ppc         <= fetch_req.vpc;
      uncached    <= (fetch_req.vpc >= 32'h8000_0000);
      paddr_valid <= 1'b1;
    end
  end

  always @(posedge clk) begin
    mem_lfsr = lfsr_next(lfsr_next(mem_lfsr));
    mem_rnd <= mem_lfsr[1:0];
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    data = apb_resp.prdata;
    err  = apb_resp.pslverr;
    check_eq(apb_resp.pready, 1'b1, "pready in access phase");
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic read_reg(input logic [11:0] addr, output logic [31:0] val);
    logic err;
    apb_read(addr, val, err);
    check_eq(err, 1'b0, "pslverr on mapped read");
  endtask

  task automatic check_result(input logic [31:0] vpc, input logic [1:0] mask);
    check_eq(out_valid, mask, "valid_o");
    check_eq(out_vpc, vpc, "vpc_o");
    check_eq(out_attached, ~vpc, "attached_o");
    for (int s = 0; s < 2; s++) begin
      if (mask[s]) begin
        check_eq(out_inst[s], expected_word({vpc[31:3], s[0], 2'b00}), "inst_o");
      end
    end
  endtask

  // Returns on the accepting edge and keeps ready_i low after it when hold_out is set
  task automatic issue_fetch(input logic [31:0] vpc, input logic [1:0] mask, input logic hold_out);
    @(posedge clk);
    fetch_req <= '{valid: mask, vpc: vpc, attached: ~vpc};
    out_ready <= 1'b1;
    do @(negedge clk); while (!fetch_ready);
    @(posedge clk);
    fetch_req.valid <= 2'b00;
    out_ready       <= !hold_out;
  endtask

  task automatic fetch_and_check(input logic [31:0] vpc, input logic [1:0] mask, input logic hit);
    int lat;
    issue_fetch(vpc, mask, 1'b0);
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!(|out_valid && fetch_ready));
    check_result(vpc, mask);
    if (hit) begin
      check_eq(lat, 1, "hit latency in cycles");
    end
  endtask

  task automatic held_fetch(input logic [31:0] vpc, input logic [1:0] mask);
    int span;
    issue_fetch(vpc, mask, 1'b1);
    do @(negedge clk); while (out_valid == 2'b00);
    span = rand_bits(3) + 1;
    repeat (span) begin
      check_result(vpc, mask);
      check_eq(fetch_ready, 1'b0, "ready_o under back-pressure");
      @(negedge clk);
    end
    @(posedge clk);
    out_ready <= 1'b1;
    @(negedge clk);
    check_eq(fetch_ready, 1'b1, "ready_o after release");
    check_result(vpc, mask);
  endtask

  task automatic cold_then_refetch();
    logic [31:0] v;
    fetch_and_check(32'h0000_0100, 2'b11, 1'b0);
    fetch_and_check(32'h0000_0100, 2'b11, 1'b1);
    read_reg(12'(REG_HITS), v);
    check_eq(v, 32'd1, "hit count");
    read_reg(12'(REG_MISSES), v);
    check_eq(v, 32'd1, "miss count");
  endtask

  task automatic slot_pairs();
    logic [31:0] bases [3];
    logic [1:0]  masks [3];
    bases[0] = 32'h0000_0200;
    bases[1] = 32'h0001_0200; // Same index as the first line
    bases[2] = 32'h0000_0340;
    masks[0] = 2'b11;
    masks[1] = 2'b01;
    masks[2] = 2'b10;
    for (int off = 0; off < 16; off += 8) begin
      for (int b = 0; b < 3; b++) begin
        fetch_and_check(bases[b] + off, masks[(b + off / 8) % 3], (off != 0) && (b == 2));
      end
    end
  endtask

  task automatic uncached_pass();
    logic [31:0] h0, h1;
    read_reg(12'(REG_HITS), h0);
    fetch_and_check(32'h8000_0010, 2'b11, 1'b0);
    fetch_and_check(32'h8000_0018, 2'b01, 1'b0);
    fetch_and_check(32'h8000_0010, 2'b10, 1'b0);
    fetch_and_check(32'hC000_1240, 2'b11, 1'b0);
    read_reg(12'(REG_HITS), h1);
    check_eq(h1, h0, "hit count after uncached fetches");
  endtask

  task automatic disable_invalidate();
    logic [31:0] h0, m0, h1, m1;
    fetch_and_check(32'h0000_0400, 2'b11, 1'b0);
    fetch_and_check(32'h0000_0400, 2'b11, 1'b1);
    apb_write(12'(REG_CTRL), 32'h0);
    read_reg(12'(REG_HITS), h0);
    read_reg(12'(REG_MISSES), m0);
    fetch_and_check(32'h0000_0400, 2'b11, 1'b0);
    read_reg(12'(REG_HITS), h1);
    read_reg(12'(REG_MISSES), m1);
    check_eq(h1, h0, "hit count with cache disabled");
    check_eq(m1, m0, "miss count with cache disabled");
    apb_write(12'(REG_CTRL), 32'h1);
    apb_write(12'(REG_CMD), 32'h1);
    read_reg(12'(REG_MISSES), m0);
    fetch_and_check(32'h0000_0400, 2'b11, 1'b0); // Waits out the sweep
    read_reg(12'(REG_MISSES), m1);
    check_eq(m1, m0 + 1, "miss count after invalidate");
  endtask

  task automatic backpressure_flush();
    held_fetch(32'h0000_0100, 2'b11);
    held_fetch(32'h0000_0a08, 2'b11);
    held_fetch(32'h8000_0200, 2'b10);
    // Drop a result that is waiting at the output
    issue_fetch(32'h0000_0100, 2'b01, 1'b1);
    do @(negedge clk); while (out_valid == 2'b00);
    @(posedge clk);
    clr <= 1'b1;
    @(posedge clk);
    clr <= 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_eq(out_valid, 2'b00, "valid_o after flush of held output");
    end
    // Drop a fetch while its refill is running
    issue_fetch(32'h0000_0b00, 2'b11, 1'b0);
    clr <= 1'b1;
    @(posedge clk);
    clr <= 1'b0;
    repeat (40) begin
      @(negedge clk);
      check_eq(out_valid, 2'b00, "valid_o after flush during refill");
    end
    fetch_and_check(32'h0000_0b00, 2'b11, 1'b1);
  endtask

  task automatic apb_errors();
    logic [31:0] v;
    logic        err;
    apb_read(12'h010, v, err);
    check_eq(err, 1'b1, "pslverr at offset 0x010");
    check_eq(v, 32'h0, "read data at offset 0x010");
    apb_read(12'h006, v, err);
    check_eq(err, 1'b1, "pslverr at offset 0x006");
    check_eq(v, 32'h0, "read data at offset 0x006");
    read_reg(12'(REG_HITS), v);
    check_eq(v != 0, 1'b1, "hit count is nonzero before clear");
    apb_write(12'(REG_HITS), 32'hFFFF_FFFF);
    read_reg(12'(REG_HITS), v);
    check_eq(v, 32'h0, "hit count after clear");
    read_reg(12'(REG_MISSES), v);
    check_eq(v != 0, 1'b1, "miss count is nonzero before clear");
    apb_write(12'(REG_MISSES), 32'h1);
    read_reg(12'(REG_MISSES), v);
    check_eq(v, 32'h0, "miss count after clear");
    read_reg(12'(REG_CTRL), v);
    check_eq(v, 32'h1, "CTRL enable");
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d clock cycles, a fetch or bus access never completed",
             TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    apb_req     = '0;
    fetch_req   = '0;
    out_ready   = 1'b1;
    clr         = 1'b0;
    ppc         = '0;
    paddr_valid = 1'b0;
    uncached    = 1'b0;
    mem_rnd     = '0;
    mem_lfsr    = 32'h2df9;
    lfsr_q      = 32'h2df9;
    checks      = 0;
    errors      = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    cold_then_refetch();
    slot_pairs();
    uncached_pass();
    disable_invalidate();
    backpressure_flush();
    apb_errors();

    repeat (2) @(posedge clk);
    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: tb_ifetch_mem.sv
`timescale 1ns/100ps

module tb_ifetch_mem (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [1:0]                  rnd_i,  // Delay and gap length
  input  ifetch_pkg::cache_bus_req_t  req_i,
  output ifetch_pkg::cache_bus_resp_t resp_o
);
  import ifetch_pkg::*;

  typedef enum logic [1:0] {M_IDLE, M_WAIT, M_BEAT} mem_state_e;

  mem_state_e  state_q;
  logic [1:0]  cnt_q;   // Cycles left before ready or the next beat
  logic [1:0]  left_q;  // Beats after the current one
  logic [31:0] addr_q;

  initial resp_o = '0;

  always @(posedge clk) begin
    if (!rst_n) begin
      state_q <= M_IDLE;
      resp_o  <= '0;
      cnt_q   <= '0;
      left_q  <= '0;
      addr_q  <= '0;
    end else begin
      resp_o.ready     <= 1'b0;
      resp_o.data_ok   <= 1'b0;
      resp_o.data_last <= 1'b0;
      case (state_q)
        M_IDLE: begin
          if (req_i.valid) begin
            addr_q  <= req_i.addr;
            left_q  <= req_i.burst_len;
            cnt_q   <= rnd_i;
            state_q <= M_WAIT;
          end
        end
        M_WAIT: begin
          if (cnt_q == 2'd0) begin
            resp_o.ready <= 1'b1;
            cnt_q        <= rnd_i; // Gap before the first beat
            state_q      <= M_BEAT;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        M_BEAT: begin
          if (cnt_q != 2'd0) begin
            cnt_q <= cnt_q - 1'b1;
          end else if (req_i.data_ok) begin // Beat only while the requester takes data
            resp_o.data_ok   <= 1'b1;
            resp_o.data_last <= (left_q == 2'd0);
            resp_o.r_data    <= addr_q ^ 32'hA5A5_0000;
            addr_q           <= addr_q + 32'd4;
            left_q           <= left_q - 1'b1;
            cnt_q            <= rnd_i;
            if (left_q == 2'd0) begin
              state_q <= M_IDLE;
            end
          end
        end
        default: state_q <= M_IDLE;
      endcase
    end
  end

endmodule

// File: ifetch_top.sv
`timescale 1ns/100ps
`include "ifetch_params.svh"

module ifetch_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  ifetch_pkg::apb_req_t        apb_i,
  output ifetch_pkg::apb_resp_t       apb_o,
  input  ifetch_pkg::fetch_req_t      fetch_i,
  output logic                        ready_o,
  input  logic [31:0]                 ppc_i,
  input  logic                        paddr_valid_i,
  input  logic                        uncached_i,
  output logic [31:0]                 vpc_o,
  output logic [1:0]                  valid_o,
  output logic [1:0][31:0]            inst_o,
  output logic [`IF_ATTACH_W-1:0]     attached_o,
  input  logic                        ready_i,
  input  logic                        clr_i,
  output ifetch_pkg::cache_bus_req_t  bus_req_o,
  input  ifetch_pkg::cache_bus_resp_t bus_resp_i
);

  logic                            cache_en, cacheop_valid, cacheop_ready;
  logic                            hit_pulse, miss_pulse, tag_hit;
  logic                            refill_we, inval_start, inval_busy;
  logic [`IF_IDX_LEN-1:0]          lookup_idx, refill_idx;
  logic [`IF_TAG_LEN-1:0]          refill_tag;
  logic [`IF_LINE_WORDS-1:0][31:0] line_data, refill_line;

  ifetch_csr u_csr (
    .clk             (clk),
    .rst_n           (rst_n),
    .apb_i           (apb_i),
    .apb_o           (apb_o),
    .cache_en_o      (cache_en),
    .cacheop_valid_o (cacheop_valid),
    .cacheop_ready_i (cacheop_ready),
    .hit_pulse_i     (hit_pulse),
    .miss_pulse_i    (miss_pulse)
  );

  core_ifetch u_fetch (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_i         (fetch_i),
    .ready_o         (ready_o),
    .ppc_i           (ppc_i),
    .paddr_valid_i   (paddr_valid_i),
    .uncached_i      (uncached_i),
    .cache_en_i      (cache_en),
    .vpc_o           (vpc_o),
    .valid_o         (valid_o),
    .inst_o          (inst_o),
    .attached_o      (attached_o),
    .ready_i         (ready_i),
    .clr_i           (clr_i),
    .cacheop_valid_i (cacheop_valid),
    .cacheop_ready_o (cacheop_ready),
    .hit_pulse_o     (hit_pulse),
    .miss_pulse_o    (miss_pulse),
    .bus_req_o       (bus_req_o),
    .bus_resp_i      (bus_resp_i),
    .lookup_idx_o    (lookup_idx),
    .tag_hit_i       (tag_hit),
    .line_data_i     (line_data),
    .refill_we_o     (refill_we),
    .refill_idx_o    (refill_idx),
    .refill_tag_o    (refill_tag),
    .refill_line_o   (refill_line),
    .inval_start_o   (inval_start),
    .inval_busy_i    (inval_busy)
  );

  // Tag compare sees the MMU output directly
  icache_arrays u_arrays (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookup_idx_i  (lookup_idx),
    .ppc_tag_i     (ppc_i[31 -: `IF_TAG_LEN]),
    .tag_hit_o     (tag_hit),
    .line_data_o   (line_data),
    .refill_we_i   (refill_we),
    .refill_idx_i  (refill_idx),
    .refill_tag_i  (refill_tag),
    .refill_line_i (refill_line),
    .inval_start_i (inval_start),
    .inval_busy_o  (inval_busy)
  );

endmodule

// File: ifetch_csr.sv
`timescale 1ns/100ps

module ifetch_csr (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ifetch_pkg::apb_req_t  apb_i,
  output ifetch_pkg::apb_resp_t apb_o,
  output logic                  cache_en_o,
  output logic                  cacheop_valid_o,
  input  logic                  cacheop_ready_i,
  input  logic                  hit_pulse_i,
  input  logic                  miss_pulse_i
);
  import ifetch_pkg::*;

  logic        access, wr_en, mapped;
  logic        wr_ctrl, wr_cmd, wr_hits, wr_misses;
  logic        en_q, op_pend_q;
  logic [31:0] hits_q, misses_q;
  logic [31:0] rd_data;

  assign access = apb_i.psel && apb_i.penable; // Access phase
  assign wr_en  = access && apb_i.pwrite;

  always_comb begin
    rd_data = '0;
    mapped  = 1'b1;
    case (apb_i.paddr[3:0])
      REG_CTRL:   rd_data = {31'b0, en_q};
      REG_CMD:    rd_data = {31'b0, op_pend_q};
      REG_HITS:   rd_data = hits_q;
      REG_MISSES: rd_data = misses_q;
      default:    mapped  = 1'b0;
    endcase
    if (apb_i.paddr[11:4] != '0) begin
      mapped  = 1'b0;
      rd_data = '0;
    end
  end

  assign wr_ctrl   = wr_en && mapped && (apb_i.paddr[3:0] == REG_CTRL);
  assign wr_cmd    = wr_en && mapped && (apb_i.paddr[3:0] == REG_CMD);
  assign wr_hits   = wr_en && mapped && (apb_i.paddr[3:0] == REG_HITS);
  assign wr_misses = wr_en && mapped && (apb_i.paddr[3:0] == REG_MISSES);

  assign apb_o.pready  = 1'b1;
  assign apb_o.prdata  = rd_data;
  assign apb_o.pslverr = access && !apb_i.pwrite && !mapped;

  assign cache_en_o      = en_q;
  assign cacheop_valid_o = op_pend_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      en_q      <= 1'b1;
      op_pend_q <= 1'b0;
      hits_q    <= '0;
      misses_q  <= '0;
    end else begin
      if (wr_ctrl) begin
        en_q <= apb_i.pwdata[0];
      end
      // A second CMD while pending is dropped
      if (op_pend_q && cacheop_ready_i) begin
        op_pend_q <= 1'b0;
      end else if (wr_cmd) begin
        op_pend_q <= 1'b1;
      end
      if (wr_hits) begin
        hits_q <= '0;
      end else if (hit_pulse_i) begin
        hits_q <= hits_q + 1'b1;
      end
      if (wr_misses) begin
        misses_q <= '0;
      end else if (miss_pulse_i) begin
        misses_q <= misses_q + 1'b1;
      end
    end
  end

  a_op_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cacheop_valid_o && !cacheop_ready_i |=> cacheop_valid_o);

endmodule

// File: core_ifetch.sv
`timescale 1ns/100ps
`include "ifetch_params.svh"

module core_ifetch (
  input  logic                            clk,
  input  logic                            rst_n,
  input  ifetch_pkg::fetch_req_t          fetch_i,
  output logic                            ready_o,
  input  logic [31:0]                     ppc_i,
  input  logic                            paddr_valid_i,
  input  logic                            uncached_i,
  input  logic                            cache_en_i,
  output logic [31:0]                     vpc_o,
  output logic [1:0]                      valid_o,
  output logic [1:0][31:0]                inst_o,
  output logic [`IF_ATTACH_W-1:0]         attached_o,
  input  logic                            ready_i,
  input  logic                            clr_i,
  input  logic                            cacheop_valid_i,
  output logic                            cacheop_ready_o,
  output logic                            hit_pulse_o,
  output logic                            miss_pulse_o,
  output ifetch_pkg::cache_bus_req_t      bus_req_o,
  input  ifetch_pkg::cache_bus_resp_t     bus_resp_i,
  output logic [`IF_IDX_LEN-1:0]          lookup_idx_o,
  input  logic                            tag_hit_i,
  input  logic [`IF_LINE_WORDS-1:0][31:0] line_data_i,
  output logic                            refill_we_o,
  output logic [`IF_IDX_LEN-1:0]          refill_idx_o,
  output logic [`IF_TAG_LEN-1:0]          refill_tag_o,
  output logic [`IF_LINE_WORDS-1:0][31:0] refill_line_o,
  output logic                            inval_start_o,
  input  logic                            inval_busy_i
);

  typedef enum logic [2:0] {
    S_IDLE, S_RF_ADDR, S_RF_DATA, S_RF_WRITE, S_PT_ADDR, S_PT_DATA, S_INVAL
  } state_e;

  // MMU result for the request in the stage, held once seen
  typedef struct packed {
    logic        valid;
    logic        unc;
    logic        hit;
    logic [31:0] ppc;
  } xlat_t;

  state_e                          state_q, state_d;
  xlat_t                           xlat_q;
  logic [31:0]                     f1_vpc_q;
  logic [1:0]                      f1_valid_q;
  logic [`IF_ATTACH_W-1:0]         f1_attached_q;
  logic                            done_q;  // Result sits in skid
  logic                            slot_q;
  logic [1:0]                      beat_q;
  logic [`IF_LINE_WORDS-1:0][31:0] line_q;
  logic [1:0][31:0]                skid_q;
  logic                            f1_full, cur_ok, cur_unc, cur_hit, avail;
  logic                            cacheop_fire, pt_last;
  logic [31:0]                     cur_ppc;

  function automatic logic [1:0][31:0] pick_pair(input logic [`IF_LINE_WORDS-1:0][31:0] line,
                                                 input logic [`IF_OFS_LEN-4:0] sel);
    return {line[{sel, 1'b1}], line[{sel, 1'b0}]};
  endfunction

  assign f1_full = |f1_valid_q;
  assign cur_ok  = xlat_q.valid | paddr_valid_i;
  assign cur_unc = xlat_q.valid ? xlat_q.unc : (uncached_i | ~cache_en_i);
  assign cur_hit = xlat_q.valid ? xlat_q.hit : tag_hit_i;
  assign cur_ppc = xlat_q.valid ? xlat_q.ppc : ppc_i;
  assign pt_last = slot_q || !f1_valid_q[1];

  assign avail = (state_q == S_IDLE) && !inval_busy_i &&
                 (done_q || (cur_ok && !cur_unc && cur_hit));
  assign cacheop_ready_o = (state_q == S_IDLE);
  assign cacheop_fire    = cacheop_valid_i && cacheop_ready_o;
  assign ready_o = ready_i && (state_q == S_IDLE) && !inval_busy_i && !cacheop_valid_i &&
                   (!f1_full || avail);

  assign valid_o    = avail ? f1_valid_q : 2'b00;
  assign inst_o     = done_q ? skid_q : pick_pair(line_data_i, f1_vpc_q[`IF_OFS_LEN-1:3]);
  assign vpc_o      = f1_vpc_q;
  assign attached_o = f1_attached_q;

  assign hit_pulse_o  = ready_o && f1_full && !done_q; // Consumed straight from the array
  assign miss_pulse_o = (state_q == S_IDLE) && (state_d == S_RF_ADDR);

  assign lookup_idx_o  = f1_vpc_q[`IF_OFS_LEN +: `IF_IDX_LEN];
  assign refill_we_o   = (state_q == S_RF_WRITE);
  assign refill_idx_o  = f1_vpc_q[`IF_OFS_LEN +: `IF_IDX_LEN];
  assign refill_tag_o  = cur_ppc[31 -: `IF_TAG_LEN];
  assign refill_line_o = line_q;
  assign inval_start_o = cacheop_fire;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (cacheop_valid_i) begin
          state_d = S_INVAL;
        end else if (f1_full && !done_q && cur_ok) begin
          if (cur_unc) begin
            state_d = S_PT_ADDR;
          end else if (!cur_hit) begin
            state_d = S_RF_ADDR;
          end
        end
      end
      S_RF_ADDR: begin
        if (bus_resp_i.ready) begin
          state_d = S_RF_DATA;
        end
      end
      S_RF_DATA: begin
        if (bus_resp_i.data_ok && bus_resp_i.data_last) begin
          state_d = S_RF_WRITE;
        end
      end
      S_RF_WRITE: state_d = S_IDLE;
      S_PT_ADDR: begin
        if (bus_resp_i.ready) begin
          state_d = S_PT_DATA;
        end
      end
      S_PT_DATA: begin
        if (bus_resp_i.data_ok) begin
          state_d = pt_last ? S_IDLE : S_PT_ADDR;
        end
      end
      S_INVAL: begin
        if (!inval_busy_i) begin
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_comb begin
    bus_req_o.valid     = 1'b0;
    bus_req_o.burst_len = 2'd0;
    bus_req_o.addr      = {cur_ppc[31:`IF_OFS_LEN], {`IF_OFS_LEN{1'b0}}}; // Line base
    bus_req_o.data_ok   = (state_q == S_RF_DATA) || (state_q == S_PT_DATA);
    if (state_q == S_RF_ADDR) begin
      bus_req_o.valid     = 1'b1;
      bus_req_o.burst_len = 2'(`IF_LINE_WORDS - 1);
    end else if (state_q == S_PT_ADDR) begin
      bus_req_o.valid = 1'b1;
      bus_req_o.addr  = {cur_ppc[31:3], slot_q, 2'b00};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= S_IDLE;
      f1_valid_q <= '0;
      done_q     <= 1'b0;
      xlat_q     <= '0;
    end else begin
      state_q <= state_d;
      if (clr_i) begin
        f1_valid_q <= '0;
      end else if (ready_o) begin
        f1_valid_q <= fetch_i.valid;
      end
      if (ready_o) begin
        done_q <= 1'b0;
      end else if (state_q == S_RF_WRITE || (state_q == S_PT_DATA && state_d == S_IDLE)) begin
        done_q <= 1'b1;
      end
      if (ready_o) begin
        xlat_q.valid <= 1'b0;
      end else begin
        if (!xlat_q.valid && paddr_valid_i && f1_full) begin
          xlat_q.valid <= 1'b1;
          xlat_q.unc   <= uncached_i | ~cache_en_i;
          xlat_q.hit   <= tag_hit_i && (state_q == S_IDLE);
          xlat_q.ppc   <= ppc_i;
        end
        if (cacheop_fire) begin
          xlat_q.hit <= 1'b0; // Line is gone after the sweep, refetch
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ready_o) begin
      f1_vpc_q      <= fetch_i.vpc;
      f1_attached_q <= fetch_i.attached;
    end
    if (state_q == S_RF_ADDR) begin
      beat_q <= '0;
    end else if (state_q == S_RF_DATA && bus_resp_i.data_ok) begin
      line_q[beat_q] <= bus_resp_i.r_data;
      beat_q         <= beat_q + 1'b1;
    end
    if (state_q == S_RF_WRITE) begin
      skid_q <= pick_pair(line_q, f1_vpc_q[`IF_OFS_LEN-1:3]);
    end else if (state_q == S_PT_DATA && bus_resp_i.data_ok) begin
      skid_q[slot_q] <= bus_resp_i.r_data;
    end
    if (state_q == S_IDLE) begin
      slot_q <= ~f1_valid_q[0]; // First valid slot
    end else if (state_q == S_PT_DATA && bus_resp_i.data_ok) begin
      slot_q <= 1'b1;
    end
  end

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_o.valid && !bus_resp_i.ready |=> bus_req_o.valid);

  a_data_in_state: assert property (@(posedge clk) disable iff (!rst_n)
    bus_resp_i.data_ok |-> (state_q inside {S_RF_DATA, S_PT_DATA}));

endmodule

// File: icache_arrays.sv
`timescale 1ns/100ps
`include "ifetch_params.svh"

module icache_arrays (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [`IF_IDX_LEN-1:0]           lookup_idx_i,
  input  logic [`IF_TAG_LEN-1:0]           ppc_tag_i,
  output logic                             tag_hit_o,
  output logic [`IF_LINE_WORDS-1:0][31:0]  line_data_o,
  input  logic                             refill_we_i,
  input  logic [`IF_IDX_LEN-1:0]           refill_idx_i,
  input  logic [`IF_TAG_LEN-1:0]           refill_tag_i,
  input  logic [`IF_LINE_WORDS-1:0][31:0]  refill_line_i,
  input  logic                             inval_start_i,
  output logic                             inval_busy_o
);

  localparam int SETS = 1 << `IF_IDX_LEN;

  logic [`IF_TAG_LEN-1:0]          tag_ram [SETS];
  logic [`IF_LINE_WORDS-1:0][31:0] data_ram [SETS];
  logic [SETS-1:0]                 valid_q;
  logic [`IF_IDX_LEN-1:0]          inval_idx_q;
  logic                            inval_busy_q;

  // Combinational read, compared against the physical tag
  assign tag_hit_o    = valid_q[lookup_idx_i] && (tag_ram[lookup_idx_i] == ppc_tag_i);
  assign line_data_o  = data_ram[lookup_idx_i];
  assign inval_busy_o = inval_busy_q;

  always_ff @(posedge clk) begin
    if (refill_we_i) begin
      tag_ram[refill_idx_i]  <= refill_tag_i;
      data_ram[refill_idx_i] <= refill_line_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q      <= '0;
      inval_busy_q <= 1'b0;
      inval_idx_q  <= '0;
    end else begin
      if (inval_busy_q) begin
        valid_q[inval_idx_q] <= 1'b0; // One set per cycle
        inval_idx_q          <= inval_idx_q + 1'b1;
        if (&inval_idx_q) begin
          inval_busy_q <= 1'b0;
        end
      end else if (inval_start_i) begin
        inval_busy_q <= 1'b1;
        inval_idx_q  <= '0;
      end
      if (refill_we_i) begin
        valid_q[refill_idx_i] <= 1'b1;
      end
    end
  end

  a_no_refill_in_inval: assert property (@(posedge clk) disable iff (!rst_n)
    refill_we_i |-> !inval_busy_q);

endmodule

// File: ifetch_pkg.sv
`include "ifetch_params.svh"

package ifetch_pkg;

  // Split request and response bus toward memory
  typedef struct packed {
    logic        valid;
    logic [1:0]  burst_len; // Beats minus one, 3 or 0
    logic [31:0] addr;
    logic        data_ok;   // Requester takes data
  } cache_bus_req_t;

  typedef struct packed {
    logic        ready;     // Address accepted
    logic        data_ok;
    logic        data_last;
    logic [31:0] r_data;
  } cache_bus_resp_t;

  typedef struct packed {
    logic [1:0]              valid; // One bit per slot
    logic [31:0]             vpc;
    logic [`IF_ATTACH_W-1:0] attached;
  } fetch_req_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
  } apb_resp_t;

  typedef enum logic [3:0] {
    REG_CTRL   = 4'h0,
    REG_CMD    = 4'h4,
    REG_HITS   = 4'h8,
    REG_MISSES = 4'hC
  } ifetch_reg_e;

endpackage

// File: ifetch_params.svh
`ifndef IFETCH_PARAMS_SVH
`define IFETCH_PARAMS_SVH

// Physical address split into tag, line index and byte offset in the line
`define IF_TAG_LEN    20
`define IF_IDX_LEN    8
`define IF_OFS_LEN    4

// Words per cache line, one refill burst
`define IF_LINE_WORDS 4

`define IF_ATTACH_W   32 // Predictor info riding with each fetch

`endif
